// File: list.f
design/icache_pkg.sv
design/icache_tag_lookup.sv
design/icache_main_fsm.sv
design/icache_refill_buf.sv
design/icache_data_array.sv
design/icache_top.sv
tb/tb_clock.sv
tb/icache_assert.sv
tb/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module icache_tb -f list.f -o icache_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/icache_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished with status 0"
exit 0

// File: tb/icache_tb.sv
`timescale 1ns/10ps

module icache_tb;
    localparam int sets     = 16;
    localparam int index_w  = $clog2(sets);
    localparam int n_fetch  = 400;
    localparam int wait_max = 500;
    localparam logic [31:0] mem_key = 32'h5a5a5a5a;

    typedef struct packed {
        logic [31:0] addr;
        logic        uncache;
        logic        hit;       // Model prediction
        logic [31:0] acc_cycle;
        logic [7:0]  mem_reqs;
    } fetch_t;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    icache_pkg::cpu_req_t  req;
    logic                  cache_ready;
    logic                  rdata_valid;
    logic [31:0]           rdata;
    logic                  mem_req_valid;
    icache_pkg::mem_req_t  mem_req;
    logic                  mem_req_ack;
    logic                  mem_rvalid;
    logic                  mem_rready;
    icache_pkg::mem_rsp_t  mem_rsp;

    fetch_t       pending [$];
    logic [3:0]   m_valid [sets];
    logic [31:0]  m_tag   [sets][4];
    logic [2:0]   m_plru  [sets];
    logic [31:0]  ncycle;
    int           answered;
    logic         fetches_done;
    logic         req_hold;
    logic [31:0]  held_addr;
    logic [7:0]   held_len;
    logic         in_refill;

    tb_clock u_clock (.clk(clk));

    icache_top #(.SETS(sets)) icache_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .cache_ready   (cache_ready),
        .rdata_valid   (rdata_valid),
        .rdata         (rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ack   (mem_req_ack),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rsp       (mem_rsp)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // tree[2] picks the pair, tree[0] decides in {0,1}, tree[1] in {2,3}
    function automatic logic [1:0] victim_way(input logic [2:0] tree);
        if (tree[2]) begin
            return {1'b1, tree[1]};
        end else begin
            return {1'b0, tree[0]};
        end
    endfunction

    function automatic logic [2:0] tree_after_visit(input logic [2:0] tree,
                                                    input logic [1:0] way);
        logic [2:0] next_tree;
        next_tree = tree;
        next_tree[2] = ~way[1]; // Point at the other pair
        if (way[1]) begin
            next_tree[1] = ~way[0];
        end else begin
            next_tree[0] = ~way[0];
        end
        return next_tree;
    endfunction

    task automatic accept_fetch(input logic [31:0] addr, input logic uncache);
        fetch_t             f;
        logic [index_w-1:0] set_i;
        logic [31:0]        tag;
        logic [1:0]         way;
        f.addr = addr;
        f.uncache = uncache;
        f.hit = 1'b0;
        f.acc_cycle = ncycle;
        f.mem_reqs = '0;
        set_i = addr[4 +: index_w];
        tag = addr >> (4 + index_w);
        way = '0;
        if (!uncache) begin // Uncached fetches leave the model alone
            for (int w = 0; w < 4; w++) begin
                if (m_valid[set_i][w] && m_tag[set_i][w] == tag) begin
                    f.hit = 1'b1;
                    way = 2'(w);
                end
            end
            if (!f.hit) begin
                way = victim_way(m_plru[set_i]);
                m_valid[set_i][way] = 1'b1;
                m_tag[set_i][way] = tag;
            end
            m_plru[set_i] = tree_after_visit(m_plru[set_i], way);
        end
        pending.push_back(f);
    endtask

    task automatic take_mem_req;
        fetch_t f;
        if (pending.size() == 0) begin
            abort_run("Memory request arrived with no fetch pending");
        end else begin
            f = pending[0];
            if (f.hit) begin
                abort_run("Memory request issued for a fetch that should hit");
            end else begin
                check_value("mem_req.addr", mem_req.addr,
                            f.uncache ? (f.addr & ~32'h3) : (f.addr & ~32'hf));
                check_value("mem_req.len", 32'(mem_req.len), f.uncache ? 32'd1 : 32'd4);
                f.mem_reqs = f.mem_reqs + 8'd1;
                pending[0] = f;
            end
        end
    endtask

    task automatic answer_fetch;
        fetch_t f;
        if (pending.size() == 0) begin
            abort_run("rdata_valid seen with no fetch pending");
        end else begin
            f = pending.pop_front();
            check_value("rdata", rdata, {f.addr[31:2], 2'b00} ^ mem_key);
            check_value("mem_req count", 32'(f.mem_reqs), f.hit ? 32'd0 : 32'd1);
            if (f.hit) begin
                check_value("hit latency", ncycle - f.acc_cycle, 32'd1);
            end
            answered++;
        end
    endtask

    // Monitor and model sample at the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            ncycle = '0;
            answered = 0;
            req_hold = 1'b0;
            in_refill = 1'b0;
            pending.delete();
            for (int s = 0; s < sets; s++) begin
                m_valid[s] = '0;
                m_plru[s] = '0;
            end
        end else begin
            ncycle = ncycle + 32'd1;
            if (req_hold) begin
                check_value("mem_req_valid", 32'(mem_req_valid), 32'd1);
                check_value("mem_req.addr", mem_req.addr, held_addr);
                check_value("mem_req.len", 32'(mem_req.len), 32'(held_len));
            end
            req_hold = mem_req_valid && !mem_req_ack;
            held_addr = mem_req.addr;
            held_len = mem_req.len;
            check_value("mem_rready", 32'(mem_rready), 32'(in_refill));
            if (mem_rvalid && mem_rready && mem_rsp.last) begin
                in_refill = 1'b0; // Burst ends at the next edge
            end
            if (mem_req_valid && mem_req_ack) begin
                take_mem_req();
                in_refill = 1'b1;
            end
            if (rdata_valid) begin
                answer_fetch(); // Answer goes before a new acceptance in the same cycle
            end
            if (req_valid && cache_ready) begin
                accept_fetch(req.addr, req.uncache);
            end
        end
    end

    // Memory responder
    initial begin
        int                   waited;
        icache_pkg::mem_req_t burst;
        logic [31:0]          beat_addr;
        mem_req_ack <= 1'b0;
        mem_rvalid <= 1'b0;
        mem_rsp <= '0;
        waited = 0;
        @(negedge clk);
        while (!rstn) begin
            waited++;
            if (waited > wait_max) begin
                abort_run("Reset was never released");
            end
            @(negedge clk);
        end
        while (!fetches_done) begin
            waited = 0;
            @(negedge clk);
            while (!mem_req_valid && !fetches_done) begin
                waited++;
                if (waited > 4 * wait_max) begin
                    abort_run("No memory request arrived in time");
                end
                @(negedge clk);
            end
            if (mem_req_valid) begin
                burst = mem_req;
                repeat ($urandom_range(0, 4)) @(posedge clk);
                @(posedge clk);
                mem_req_ack <= 1'b1;
                @(posedge clk);
                mem_req_ack <= 1'b0;
                for (int b = 0; b < int'(burst.len); b++) begin
                    repeat ($urandom_range(0, 2)) begin
                        mem_rvalid <= 1'b0;
                        @(posedge clk);
                    end
                    beat_addr = burst.addr + 32'(4 * b);
                    mem_rvalid <= 1'b1;
                    mem_rsp.data <= beat_addr ^ mem_key;
                    mem_rsp.last <= (b == int'(burst.len) - 1);
                    @(posedge clk);
                end
                mem_rvalid <= 1'b0;
            end
        end
    end

    initial begin
        int          gap;
        int          waited;
        logic [31:0] addr;
        void'($urandom(32'hdcf3364d));
        rstn <= 1'b0;
        req_valid <= 1'b0;
        req <= '0;
        fetches_done <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < n_fetch; i++) begin
            gap = ($urandom_range(0, 2) == 0) ? int'($urandom_range(1, 4)) : 0;
            repeat (gap) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
            addr = 32'h0040_0000 | ($urandom & 32'h0000_07fc); // 128 lines over 16 sets
            req_valid <= 1'b1;
            req.addr <= addr;
            req.uncache <= ($urandom_range(0, 7) == 0);
            waited = 0;
            @(negedge clk);
            while (!cache_ready) begin
                waited++;
                if (waited > wait_max) begin
                    abort_run("cache_ready stayed low too long");
                end
                @(negedge clk);
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;
        waited = 0;
        while (answered < n_fetch && waited < wait_max) begin
            @(negedge clk);
            waited++;
        end
        fetches_done <= 1'b1;
        if (answered == n_fetch && pending.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Only %0d of %0d fetches were answered", answered, n_fetch);
            $display("TESTBENCH FAILED");
            $fatal(1, "Fetches left unanswered");
        end
    end

endmodule

// File: tb/icache_assert.sv
`timescale 1ns/10ps

module icache_assert (
    input logic                  clk,
    input logic                  rstn,
    input logic                  cache_ready,
    input logic                  rdata_valid,
    input logic                  mem_req_valid,
    input icache_pkg::mem_req_t  mem_req,
    input logic                  mem_req_ack
);

    // Request stays on the bus until memory takes it
    mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_req_ack |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed or dropped before mem_req_ack");

    // mem_req_valid is high only in REPLACE
    no_answer_in_replace: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_req_valid && rdata_valid))
        else $error("rdata_valid high while the memory request is pending");

    ready_after_reset: assert property (@(posedge clk) $rose(rstn) |-> cache_ready)
        else $error("cache_ready low in the first cycle after reset");

endmodule

bind icache_top icache_assert icache_assert_inst (
    .clk           (clk),
    .rstn          (rstn),
    .cache_ready   (cache_ready),
    .rdata_valid   (rdata_valid),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ack   (mem_req_ack)
);

// File: tb/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk; // 8 ns period
        end
    end

endmodule

// File: design/icache_top.sv
`timescale 1ns/10ps

module icache_top #(
    parameter int SETS = 16
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           req_valid,
    input  icache_pkg::cpu_req_t           req,
    output logic                           cache_ready,
    output logic                           rdata_valid,
    output logic [icache_pkg::data_w-1:0]  rdata,
    output logic                           mem_req_valid,
    output icache_pkg::mem_req_t           mem_req,
    input  logic                           mem_req_ack,
    input  logic                           mem_rvalid,
    output logic                           mem_rready,
    input  icache_pkg::mem_rsp_t           mem_rsp
);
    logic [icache_pkg::ways-1:0]    hit;
    logic                           cache_hit;
    logic [icache_pkg::ways-1:0]    lru_way;
    logic                           uncache;
    logic [$clog2(SETS)-1:0]        index;
    logic [1:0]                     word_sel;
    logic [icache_pkg::addr_w-1:0]  line_addr;
    logic                           req_latch;
    logic                           rdata_sel;
    logic [7:0]                     burst_len;
    logic [icache_pkg::ways-1:0]    tag_we;
    logic [icache_pkg::ways-1:0]    mem_we;
    logic [icache_pkg::ways-1:0]    way_visit;
    logic                           way_sel_en;
    logic                           fill_finish;
    logic [icache_pkg::line_words*icache_pkg::data_w-1:0] line_data;

    assign mem_req.addr = line_addr;
    assign mem_req.len  = burst_len;

    icache_main_fsm u_main_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .cache_hit     (cache_hit),
        .hit           (hit),
        .lru_way       (lru_way),
        .uncache       (uncache),
        .mem_req_ack   (mem_req_ack),
        .fill_finish   (fill_finish),
        .cache_ready   (cache_ready),
        .req_latch     (req_latch),
        .rdata_valid   (rdata_valid),
        .rdata_sel     (rdata_sel),
        .mem_req_valid (mem_req_valid),
        .burst_len     (burst_len),
        .mem_rready    (mem_rready),
        .tag_we        (tag_we),
        .mem_we        (mem_we),
        .way_visit     (way_visit),
        .way_sel_en    (way_sel_en)
    );

    icache_tag_lookup #(.SETS(SETS)) u_tag_lookup (
        .clk        (clk),
        .rstn       (rstn),
        .req_latch  (req_latch),
        .req        (req),
        .tag_we     (tag_we),
        .way_visit  (way_visit),
        .way_sel_en (way_sel_en),
        .hit        (hit),
        .cache_hit  (cache_hit),
        .lru_way    (lru_way),
        .uncache    (uncache),
        .index      (index),
        .word_sel   (word_sel),
        .line_addr  (line_addr)
    );

    icache_refill_buf u_refill_buf (
        .clk         (clk),
        .rstn        (rstn),
        .mem_rready  (mem_rready),
        .mem_rvalid  (mem_rvalid),
        .mem_rsp     (mem_rsp),
        .fill_finish (fill_finish),
        .line_data   (line_data)
    );

    icache_data_array #(.SETS(SETS)) u_data_array (
        .clk       (clk),
        .index     (index),
        .word_sel  (word_sel),
        .hit       (hit),
        .mem_we    (mem_we),
        .line_data (line_data),
        .rdata_sel (rdata_sel),
        .uncache   (uncache),
        .rdata     (rdata)
    );

endmodule

// File: design/icache_data_array.sv
`timescale 1ns/10ps

module icache_data_array #(
    parameter int SETS = 16
) (
    input  logic                                                  clk,
    input  logic [$clog2(SETS)-1:0]                               index,
    input  logic [1:0]                                            word_sel,
    input  logic [icache_pkg::ways-1:0]                           hit,
    input  logic [icache_pkg::ways-1:0]                           mem_we,
    input  logic [icache_pkg::line_words*icache_pkg::data_w-1:0]  line_data,
    input  logic                                                  rdata_sel,
    input  logic                                                  uncache,
    output logic [icache_pkg::data_w-1:0]                         rdata
);
    localparam int line_w = icache_pkg::line_words * icache_pkg::data_w;

    logic [line_w-1:0] line_mem [icache_pkg::ways][SETS];
    logic [line_w-1:0] hit_line;

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (mem_we[w]) begin
                line_mem[w][index] <= line_data;
            end
        end
    end

    // Hit vector is one-hot, so an OR works as the way mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (hit[w]) begin
                hit_line = hit_line | line_mem[w][index];
            end
        end
    end

    always_comb begin
        if (rdata_sel) begin
            rdata = hit_line[word_sel*icache_pkg::data_w +: icache_pkg::data_w];
        end else if (uncache) begin
            rdata = line_data[icache_pkg::data_w-1:0]; // Single word sits in slot 0
        end else begin
            rdata = line_data[word_sel*icache_pkg::data_w +: icache_pkg::data_w];
        end
    end

endmodule

// File: design/icache_refill_buf.sv
`timescale 1ns/10ps

module icache_refill_buf (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     mem_rready,
    input  logic                     mem_rvalid,
    input  icache_pkg::mem_rsp_t     mem_rsp,
    output logic                     fill_finish,
    output logic [icache_pkg::line_words*icache_pkg::data_w-1:0] line_data
);
    localparam int cnt_w = $clog2(icache_pkg::line_words);

    logic [cnt_w-1:0]              beat_cnt;
    logic [icache_pkg::data_w-1:0] slot_q [icache_pkg::line_words];
    logic                          beat;

    assign beat        = mem_rready && mem_rvalid;
    assign fill_finish = beat && mem_rsp.last;

    // A single-word burst lands in slot 0
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= mem_rsp.last ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            slot_q[beat_cnt] <= mem_rsp.data;
        end
    end

    // Last beat is forwarded so the line is complete in the finishing cycle
    always_comb begin
        for (int i = 0; i < icache_pkg::line_words; i++) begin
            if (fill_finish && beat_cnt == cnt_w'(i)) begin
                line_data[i*icache_pkg::data_w +: icache_pkg::data_w] = mem_rsp.data;
            end else begin
                line_data[i*icache_pkg::data_w +: icache_pkg::data_w] = slot_q[i];
            end
        end
    end

endmodule

// File: design/icache_main_fsm.sv
`timescale 1ns/10ps

module icache_main_fsm (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_valid,
    input  logic                         cache_hit,
    input  logic [icache_pkg::ways-1:0]  hit,
    input  logic [icache_pkg::ways-1:0]  lru_way,
    input  logic                         uncache,
    input  logic                         mem_req_ack,
    input  logic                         fill_finish,
    output logic                         cache_ready,
    output logic                         req_latch,
    output logic                         rdata_valid,
    output logic                         rdata_sel,
    output logic                         mem_req_valid,
    output logic [7:0]                   burst_len,
    output logic                         mem_rready,
    output logic [icache_pkg::ways-1:0]  tag_we,
    output logic [icache_pkg::ways-1:0]  mem_we,
    output logic [icache_pkg::ways-1:0]  way_visit,
    output logic                         way_sel_en
);
    icache_pkg::fsm_state_t state;
    icache_pkg::fsm_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= icache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (req_valid) begin
                    next_state = icache_pkg::LOOKUP;
                end
            end
            icache_pkg::LOOKUP: begin
                if (uncache || !cache_hit) begin
                    next_state = icache_pkg::REPLACE;
                end else if (!req_valid) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            icache_pkg::REPLACE: begin
                if (mem_req_ack) begin
                    next_state = icache_pkg::REFILL;
                end
            end
            icache_pkg::REFILL: begin
                if (fill_finish) begin
                    next_state = req_valid ? icache_pkg::LOOKUP : icache_pkg::IDLE;
                end
            end
            default: next_state = icache_pkg::IDLE;
        endcase
    end

    always_comb begin
        cache_ready   = 1'b0;
        req_latch     = 1'b0;
        rdata_valid   = 1'b0;
        rdata_sel     = 1'b0;
        mem_req_valid = 1'b0;
        burst_len     = 8'(icache_pkg::line_words);
        mem_rready    = 1'b0;
        tag_we        = '0;
        mem_we        = '0;
        way_visit     = '0;
        way_sel_en    = 1'b0;
        case (state)
            icache_pkg::IDLE: begin
                cache_ready = 1'b1;
                req_latch   = req_valid;
            end
            icache_pkg::LOOKUP: begin
                if (cache_hit && !uncache) begin
                    rdata_valid = 1'b1;
                    rdata_sel   = 1'b1;
                    way_visit   = hit;
                    way_sel_en  = 1'b1;
                    cache_ready = 1'b1; // Next fetch may enter while this one is answered
                    req_latch   = req_valid;
                end
            end
            icache_pkg::REPLACE: begin
                mem_req_valid = 1'b1;
                if (uncache) begin
                    burst_len = 8'd1;
                end
            end
            icache_pkg::REFILL: begin
                mem_rready = 1'b1;
                if (fill_finish) begin
                    if (!uncache) begin
                        tag_we     = lru_way;
                        mem_we     = lru_way;
                        way_visit  = lru_way;
                        way_sel_en = 1'b1;
                    end
                    rdata_valid = 1'b1;
                    cache_ready = 1'b1;
                    req_latch   = req_valid;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/icache_tag_lookup.sv
`timescale 1ns/10ps

module icache_tag_lookup #(
    parameter int SETS = 16
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            req_latch,
    input  icache_pkg::cpu_req_t            req,
    input  logic [icache_pkg::ways-1:0]     tag_we,
    input  logic [icache_pkg::ways-1:0]     way_visit,
    input  logic                            way_sel_en,
    output logic [icache_pkg::ways-1:0]     hit,
    output logic                            cache_hit,
    output logic [icache_pkg::ways-1:0]     lru_way,
    output logic                            uncache,
    output logic [$clog2(SETS)-1:0]         index,
    output logic [1:0]                      word_sel,
    output logic [icache_pkg::addr_w-1:0]   line_addr
);
    localparam int index_w = $clog2(SETS);
    localparam int tag_w   = icache_pkg::addr_w - index_w - icache_pkg::offset_w;

    icache_pkg::cpu_req_t          req_q;
    logic [tag_w-1:0]              tag_mem [icache_pkg::ways][SETS];
    logic [icache_pkg::ways-1:0]   valid_q [SETS];
    logic [2:0]                    plru_q  [SETS]; // [2] pair select, [1] ways 2/3, [0] ways 0/1
    logic [tag_w-1:0]              tag;
    logic [2:0]                    plru;

    always_ff @(posedge clk) begin
        if (req_latch) begin
            req_q <= req;
        end
    end

    assign tag      = req_q.addr[icache_pkg::addr_w-1 -: tag_w];
    assign index    = req_q.addr[icache_pkg::offset_w +: index_w];
    assign word_sel = req_q.addr[icache_pkg::offset_w-1:2];
    assign uncache  = req_q.uncache;

    // Uncached reads fetch just the addressed word
    assign line_addr = req_q.uncache ? {req_q.addr[icache_pkg::addr_w-1:2], 2'b00}
                     : {req_q.addr[icache_pkg::addr_w-1:icache_pkg::offset_w],
                        {icache_pkg::offset_w{1'b0}}};

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][index] <= tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            hit[w] = valid_q[index][w] && (tag_mem[w][index] == tag);
        end
    end

    assign cache_hit = |hit;
    assign plru      = plru_q[index];

    // Victim follows the tree bits
    always_comb begin
        if (!plru[2]) begin
            lru_way = plru[0] ? 4'b0010 : 4'b0001;
        end else begin
            lru_way = plru[1] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            valid_q[index] <= valid_q[index] | tag_we;
            if (way_sel_en) begin
                case (way_visit) // Point away from the visited way
                    4'b0001: plru_q[index] <= {1'b1, plru[1], 1'b1};
                    4'b0010: plru_q[index] <= {1'b1, plru[1], 1'b0};
                    4'b0100: plru_q[index] <= {1'b0, 1'b1, plru[0]};
                    4'b1000: plru_q[index] <= {1'b0, 1'b0, plru[0]};
                    default: plru_q[index] <= plru;
                endcase
            end
        end
    end

endmodule

// File: design/icache_pkg.sv
package icache_pkg;

    localparam int addr_w     = 32;
    localparam int data_w     = 32;
    localparam int ways       = 4;
    localparam int line_words = 4;
    localparam int offset_w   = 4; // Byte offset inside a 16-byte line

    // Fetch request from the processor
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              uncache;
    } cpu_req_t;

    // Burst read request to memory
    typedef struct packed {
        logic [addr_w-1:0] addr; // Word aligned start
        logic [7:0]        len;  // Words in the burst, 4 or 1
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic              last;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL
    } fsm_state_t;

endpackage
